// ==== all.f ====
hw/uart_pkg.sv
hw/baud_tick_gen.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/link_ctrl.sv
hw/uart_link_top.sv
test/uart_link_checker.sv
test/tb_uart_link.sv

// ==== hw/baud_tick_gen.sv ====
`default_nettype none
`timescale 1ns/1ps

module baud_tick_gen #(
    parameter int div = 5
) (
    input  logic clk,
    input  logic reset,
    output logic tick
);

    localparam int cnt_w = (div > 1) ? $clog2(div) : 1;

    logic [cnt_w-1:0] cnt;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            cnt  <= '0;
            tick <= 1'b0;
        end
        else if (cnt == cnt_w'(div - 1))
        begin
            cnt  <= '0;
            tick <= 1'b1;  // one pulse per wrap
        end
        else
        begin
            cnt  <= cnt + 1'b1;
            tick <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// ==== hw/link_ctrl.sv ====
`default_nettype none
`timescale 1ns/1ps

module link_ctrl (
    input  logic                   clk,
    input  logic                   reset,
    input  uart_pkg::wb_req_t      wb_req,
    output uart_pkg::wb_rsp_t      wb_rsp,
    input  logic                   tx_busy,
    output uart_pkg::tx_req_t      tx_req,
    input  uart_pkg::rx_result_t   rx_result
);

    localparam int retry_w = $clog2(uart_pkg::max_retries + 1);

    logic                 ack_q;
    uart_pkg::data_t      rsp_dat_q;
    uart_pkg::data_t      last_byte;
    uart_pkg::data_t      rx_byte;
    logic                 rx_valid;
    logic                 retry_pending;
    logic                 start_pending;
    logic                 link_failed;
    logic [retry_w-1:0]   retry_cnt;
    uart_pkg::status_t    status;
    logic                 req_seen;
    logic                 is_read;
    logic                 is_data_wr;
    logic                 tx_free;
    logic                 ack_d;
    logic                 start;
    logic                 rx_good;

    assign req_seen   = wb_req.cyc && wb_req.stb && !ack_q;
    assign is_read    = !wb_req.we;
    assign is_data_wr = wb_req.we && wb_req.adr == uart_pkg::addr_data;
    assign tx_free    = !tx_busy && !retry_pending && !start_pending;
    // data writes wait for the transmitter, everything else answers at once
    assign ack_d      = req_seen && (!is_data_wr || tx_free);

    assign start   = (start_pending || retry_pending) && !tx_busy;
    assign rx_good = rx_result.parity_ok && rx_result.stop_ok;

    assign status = uart_pkg::status_t'{
        zero:          4'b0,
        link_failed:   link_failed,
        retry_pending: retry_pending,
        rx_valid:      rx_valid,
        tx_busy:       tx_busy
    };

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            ack_q         <= 1'b0;
            rx_valid      <= 1'b0;
            retry_pending <= 1'b0;
            start_pending <= 1'b0;
            link_failed   <= 1'b0;
            retry_cnt     <= '0;
        end
        else
        begin
            ack_q <= ack_d;
            if (start)
            begin
                start_pending <= 1'b0;
                retry_pending <= 1'b0;
            end
            if (ack_d && is_read && wb_req.adr == uart_pkg::addr_data)
            begin
                rx_valid <= 1'b0;  // data read pops the byte
            end
            if (ack_d && is_data_wr)
            begin
                start_pending <= 1'b1;
                link_failed   <= 1'b0;
                retry_cnt     <= '0;
            end
            if (rx_result.valid)
            begin
                if (rx_good)
                begin
                    rx_valid  <= 1'b1;
                    retry_cnt <= '0;
                end
                else if (retry_cnt < retry_w'(uart_pkg::max_retries))
                begin
                    retry_pending <= 1'b1;
                    retry_cnt     <= retry_cnt + 1'b1;
                end
                else
                begin
                    link_failed <= 1'b1;  // give up on this byte
                end
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (ack_d && is_data_wr)
        begin
            last_byte <= wb_req.dat;
        end
        if (rx_result.valid && rx_good)
        begin
            rx_byte <= rx_result.data;
        end
        if (ack_d && is_read)
        begin
            rsp_dat_q <= (wb_req.adr == uart_pkg::addr_status) ? status : rx_byte;
        end
    end

    assign wb_rsp = uart_pkg::wb_rsp_t'{ack: ack_q, dat: rsp_dat_q};
    assign tx_req = uart_pkg::tx_req_t'{start: start, data: last_byte};

endmodule

`default_nettype wire

// ==== hw/uart_link_top.sv ====
`default_nettype none
`timescale 1ns/1ps

module uart_link_top #(
    parameter int sample_div = 5
) (
    input  logic                clk,
    input  logic                reset,
    input  uart_pkg::wb_req_t   wb_req,
    output uart_pkg::wb_rsp_t   wb_rsp,
    output logic                serial_out,
    input  logic                serial_in
);

    // one bit lasts oversample sample ticks
    localparam int bit_div = sample_div * uart_pkg::oversample;

    logic                   sample_tick;
    logic                   bit_tick;
    logic                   tx_busy;
    uart_pkg::tx_req_t      tx_req;
    uart_pkg::rx_result_t   rx_result;

    baud_tick_gen #(.div(sample_div)) u_sample_tick (
        .clk   (clk),
        .reset (reset),
        .tick  (sample_tick)
    );

    baud_tick_gen #(.div(bit_div)) u_bit_tick (
        .clk   (clk),
        .reset (reset),
        .tick  (bit_tick)
    );

    uart_tx u_tx (
        .clk        (clk),
        .reset      (reset),
        .bit_tick   (bit_tick),
        .req        (tx_req),
        .busy       (tx_busy),
        .serial_out (serial_out)
    );

    uart_rx u_rx (
        .clk         (clk),
        .reset       (reset),
        .sample_tick (sample_tick),
        .serial_in   (serial_in),
        .result      (rx_result)
    );

    link_ctrl u_ctrl (
        .clk       (clk),
        .reset     (reset),
        .wb_req    (wb_req),
        .wb_rsp    (wb_rsp),
        .tx_busy   (tx_busy),
        .tx_req    (tx_req),
        .rx_result (rx_result)
    );

endmodule

`default_nettype wire

// ==== hw/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

    typedef logic [7:0] data_t;
    typedef logic [10:0] frame_t;
    typedef logic [3:0] bit_cnt_t;
    typedef logic [2:0] sample_cnt_t;
    typedef logic [0:0] wb_addr_t;

    localparam int oversample = 8;   // samples per bit
    localparam int frame_bits = 11;  // start + 8 data + parity + stop
    localparam int max_retries = 3;

    localparam wb_addr_t addr_data = 1'b0;
    localparam wb_addr_t addr_status = 1'b1;

    typedef struct packed {
        logic cyc;
        logic stb;
        logic we;
        wb_addr_t adr;
        data_t dat;
    } wb_req_t;

    typedef struct packed {
        logic ack;
        data_t dat;
    } wb_rsp_t;

    // one-cycle start with the byte to send
    typedef struct packed {
        logic start;
        data_t data;
    } tx_req_t;

    typedef struct packed {
        logic valid;
        data_t data;
        logic parity_ok;
        logic stop_ok;
    } rx_result_t;

    typedef struct packed {
        logic [3:0] zero;
        logic link_failed;
        logic retry_pending;
        logic rx_valid;
        logic tx_busy;
    } status_t;

    typedef enum logic [2:0] {
        rx_idle,
        rx_start,
        rx_data,
        rx_parity,
        rx_stop
    } rx_state_t;

endpackage

`default_nettype wire

// ==== hw/uart_rx.sv ====
`default_nettype none
`timescale 1ns/1ps

module uart_rx (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   sample_tick,
    input  logic                   serial_in,
    output uart_pkg::rx_result_t   result
);

    // phase of the start bit centre, counted from the first low sample
    localparam uart_pkg::sample_cnt_t centre =
        uart_pkg::sample_cnt_t'(uart_pkg::oversample / 2 - 1);
    localparam uart_pkg::sample_cnt_t last =
        uart_pkg::sample_cnt_t'(uart_pkg::oversample - 1);
    localparam uart_pkg::bit_cnt_t last_data_bit =
        uart_pkg::bit_cnt_t'($bits(uart_pkg::data_t) - 1);

    uart_pkg::rx_state_t   state;
    uart_pkg::sample_cnt_t phase;
    uart_pkg::bit_cnt_t    bit_cnt;
    uart_pkg::data_t       shift_q;
    logic                  valid_q;
    logic                  parity_ok_q;
    logic                  stop_ok_q;
    logic                  at_centre;

    // one full bit after the previous centre
    assign at_centre = sample_tick && (phase == last);

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            state       <= uart_pkg::rx_idle;
            phase       <= '0;
            bit_cnt     <= '0;
            valid_q     <= 1'b0;
            parity_ok_q <= 1'b0;
            stop_ok_q   <= 1'b0;
        end
        else
        begin
            valid_q <= 1'b0;
            if (sample_tick)
            begin
                case (state)
                    uart_pkg::rx_idle:
                    begin
                        if (!serial_in)
                        begin
                            state <= uart_pkg::rx_start;
                            phase <= '0;
                        end
                    end
                    uart_pkg::rx_start:
                    begin
                        if (phase == centre)
                        begin
                            phase   <= '0;
                            bit_cnt <= '0;
                            // glitch if the line went back high
                            state   <= serial_in ? uart_pkg::rx_idle : uart_pkg::rx_data;
                        end
                        else
                        begin
                            phase <= phase + 1'b1;
                        end
                    end
                    uart_pkg::rx_data:
                    begin
                        phase <= phase + 1'b1;  // wraps at 8
                        if (phase == last)
                        begin
                            bit_cnt <= bit_cnt + 1'b1;
                            if (bit_cnt == last_data_bit)
                            begin
                                state <= uart_pkg::rx_parity;
                            end
                        end
                    end
                    uart_pkg::rx_parity:
                    begin
                        phase <= phase + 1'b1;
                        if (phase == last)
                        begin
                            parity_ok_q <= ^{serial_in, shift_q};  // odd count of ones
                            state       <= uart_pkg::rx_stop;
                        end
                    end
                    uart_pkg::rx_stop:
                    begin
                        phase <= phase + 1'b1;
                        if (phase == last)
                        begin
                            stop_ok_q <= serial_in;
                            valid_q   <= 1'b1;
                            state     <= uart_pkg::rx_idle;
                        end
                    end
                    default:
                    begin
                        state <= uart_pkg::rx_idle;
                    end
                endcase
            end
        end
    end

    // data bits arrive lsb first
    always_ff @(posedge clk)
    begin
        if (at_centre && state == uart_pkg::rx_data)
        begin
            shift_q <= {serial_in, shift_q[7:1]};
        end
    end

    assign result = uart_pkg::rx_result_t'{
        valid:     valid_q,
        data:      shift_q,
        parity_ok: parity_ok_q,
        stop_ok:   stop_ok_q
    };

endmodule

`default_nettype wire

// ==== hw/uart_tx.sv ====
`default_nettype none
`timescale 1ns/1ps

module uart_tx (
    input  logic                clk,
    input  logic                reset,
    input  logic                bit_tick,
    input  uart_pkg::tx_req_t   req,
    output logic                busy,
    output logic                serial_out
);

    uart_pkg::frame_t   shift_q;
    uart_pkg::bit_cnt_t bit_cnt;
    logic               parity;
    logic               load;
    logic               advance;

    assign parity  = ~(^req.data);  // odd parity over the byte
    assign load    = !busy && req.start;
    assign advance = busy && bit_tick;

    // control and line driver
    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            busy       <= 1'b0;
            serial_out <= 1'b1;
            bit_cnt    <= '0;
        end
        else if (load)
        begin
            busy    <= 1'b1;
            bit_cnt <= '0;
        end
        else if (advance)
        begin
            if (bit_cnt == uart_pkg::bit_cnt_t'(uart_pkg::frame_bits))
            begin
                // stop bit has now had its full period
                busy       <= 1'b0;
                serial_out <= 1'b1;
            end
            else
            begin
                serial_out <= shift_q[0];  // lsb first
                bit_cnt    <= bit_cnt + 1'b1;
            end
        end
    end

    // frame is {stop, parity, data, start}
    always_ff @(posedge clk)
    begin
        if (load)
        begin
            shift_q <= {1'b1, parity, req.data, 1'b0};
        end
        else if (advance)
        begin
            shift_q <= {1'b1, shift_q[uart_pkg::frame_bits-1:1]};
        end
    end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# builds the UART loopback testbench with Verilator and runs it
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -j 0 --top-module tb_uart_link -f all.f
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

# assertion errors are counted by the testbench, which then ends the run
./obj_dir/Vtb_uart_link +verilator+error+limit+1000
status=$?
if [ $status -ne 0 ]; then
    echo "simulation failed with status $status"
    exit 1
fi

echo "simulation finished cleanly"
exit 0

// ==== test/tb_uart_link.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_uart_link;

    localparam int bit_cycles = 16;  // sample_div of 2 times oversample
    localparam int frame_cycles = uart_pkg::frame_bits * bit_cycles;
    localparam int bytes_sent = 9;
    localparam int cycle_limit = 20 * frame_cycles * bytes_sent + 2000;

    logic              clk;
    logic              reset = 1'b1;
    uart_pkg::wb_req_t wb_req = '0;
    uart_pkg::wb_rsp_t wb_rsp;
    logic              serial_out;
    logic              serial_in = 1'b1;

    integer seed;
    int     cycle_cnt = 0;
    int     frames_seen = 0;
    int     frame_pos = 0;
    int     corrupt_upto = 0;     // frames with a lower index get a bad parity bit
    logic   corrupt_all = 1'b0;
    logic   corrupt_frame = 1'b0;
    logic   corrupt = 1'b0;
    logic   in_frame = 1'b0;
    logic   line_q = 1'b1;

    uart_link_top #(.sample_div(2)) uut (
        .clk        (clk),
        .reset      (reset),
        .wb_req     (wb_req),
        .wb_rsp     (wb_rsp),
        .serial_out (serial_out),
        .serial_in  (serial_in)
    );

    initial
    begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // external loopback, flips only the parity bit of chosen frames
    always @(negedge clk)
    begin
        if (reset)
        begin
            in_frame  = 1'b0;
            line_q    = 1'b1;
            corrupt   = 1'b0;
            serial_in = 1'b1;
        end
        else
        begin
            if (!in_frame && line_q && !serial_out)
            begin
                in_frame      = 1'b1;
                frame_pos     = 0;
                corrupt_frame = corrupt_all || (frames_seen < corrupt_upto);
                frames_seen++;
            end
            else if (in_frame)
            begin
                frame_pos++;
                if (frame_pos == frame_cycles - 1)
                begin
                    in_frame = 1'b0;
                end
            end
            corrupt   = in_frame && corrupt_frame && (frame_pos / bit_cycles == 9);
            serial_in = serial_out ^ corrupt;
            line_q    = serial_out;
        end
    end

    always @(negedge clk)
    begin
        cycle_cnt++;
        if (cycle_cnt > cycle_limit)
        begin
            $display("timeout: no progress from the DUT after %0d cycles", cycle_cnt);
            fail_run();
        end
        else if (uut.u_checker.failures != 0)
        begin
            $display("a concurrent assertion in the checker failed");
            fail_run();
        end
    end

    task automatic fail_run();
        $display("Testbench failed");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input int got, input int exp);
        if (got !== exp)
        begin
            $display("error at %0d ns: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
            fail_run();
        end
    endtask

    // called on a falling edge, returns on one
    task automatic write_reg(input uart_pkg::wb_addr_t adr, input uart_pkg::data_t dat);
        wb_req = uart_pkg::wb_req_t'{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
        @(negedge clk);
        while (!wb_rsp.ack)
        begin
            @(negedge clk);
        end
        wb_req = '0;
        @(negedge clk);
    endtask

    task automatic read_reg(input uart_pkg::wb_addr_t adr, output uart_pkg::data_t dat);
        wb_req = uart_pkg::wb_req_t'{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 8'h00};
        @(negedge clk);
        while (!wb_rsp.ack)
        begin
            @(negedge clk);
        end
        dat    = wb_rsp.dat;
        wb_req = '0;
        @(negedge clk);
    endtask

    task automatic read_status(output uart_pkg::status_t st);
        uart_pkg::data_t raw;

        read_reg(uart_pkg::addr_status, raw);
        st = uart_pkg::status_t'(raw);
    endtask

    task automatic wait_status(input logic want_failed);
        uart_pkg::status_t st;

        read_status(st);
        while (!(want_failed ? st.link_failed : st.rx_valid))
        begin
            read_status(st);
        end
    endtask

    task automatic loop_byte(input uart_pkg::data_t b);
        uart_pkg::data_t   got;
        uart_pkg::status_t st;
        int                frames_before;

        frames_before = frames_seen;
        write_reg(uart_pkg::addr_data, b);
        read_status(st);
        check_value("link_failed after a write", int'(st.link_failed), 0);
        wait_status(1'b0);
        read_reg(uart_pkg::addr_data, got);
        check_value("looped byte", int'(got), int'(b));
        check_value("frames for a clean byte", frames_seen - frames_before, 1);
        read_status(st);
        check_value("rx_valid after data read", int'(st.rx_valid), 0);
    endtask

    initial
    begin
        uart_pkg::data_t   b;
        uart_pkg::data_t   first;
        uart_pkg::data_t   got;
        uart_pkg::status_t st;
        int                frames_before;

        seed = 32'h9cfd549b;
        repeat (2) @(negedge clk);
        reset = 1'b0;

        read_status(st);
        check_value("status after reset", int'(st), 0);

        repeat (4) loop_byte(uart_pkg::data_t'($random(seed)));

        // parity of the first frame only is flipped
        frames_before = frames_seen;
        corrupt_upto  = frames_seen + 1;
        b = uart_pkg::data_t'($random(seed));
        write_reg(uart_pkg::addr_data, b);
        wait_status(1'b0);
        read_reg(uart_pkg::addr_data, got);
        check_value("byte after one resend", int'(got), int'(b));
        check_value("frames with one resend", frames_seen - frames_before, 2);
        read_status(st);
        check_value("link_failed after one resend", int'(st.link_failed), 0);

        // every frame corrupted until the controller gives up
        frames_before = frames_seen;
        corrupt_all   = 1'b1;
        write_reg(uart_pkg::addr_data, uart_pkg::data_t'($random(seed)));
        wait_status(1'b1);
        read_status(st);
        check_value("rx_valid after link failure", int'(st.rx_valid), 0);
        check_value("frames before link failure", frames_seen - frames_before,
            uart_pkg::max_retries + 1);
        corrupt_all = 1'b0;
        loop_byte(uart_pkg::data_t'($random(seed)));

        // second write waits for the first frame to leave
        first = uart_pkg::data_t'($random(seed));
        b     = uart_pkg::data_t'($random(seed));
        write_reg(uart_pkg::addr_data, first);
        write_reg(uart_pkg::addr_data, b);
        wait_status(1'b0);
        read_reg(uart_pkg::addr_data, got);
        check_value("first byte of a pair", int'(got), int'(first));
        wait_status(1'b0);
        read_reg(uart_pkg::addr_data, got);
        check_value("second byte of a pair", int'(got), int'(b));

        if (uut.u_checker.failures != 0)
        begin
            $display("a concurrent assertion in the checker failed");
            fail_run();
        end
        else
        begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== test/uart_link_checker.sv ====
`default_nettype none
`timescale 1ns/1ps

module uart_link_checker (
    input  logic                clk,
    input  logic                reset,
    input  uart_pkg::wb_req_t   wb_req,
    input  uart_pkg::wb_rsp_t   wb_rsp,
    input  logic                serial_out,
    input  logic                tx_busy,
    input  uart_pkg::tx_req_t   tx_req,
    input  uart_pkg::status_t   status
);

    int unsigned failures = 0;  // polled by the testbench

    uart_pkg::data_t    exp_data;
    uart_pkg::bit_cnt_t idx;
    logic [3:0]         phase;  // cycles into the current bit, 16 per bit
    logic               armed;
    logic               in_frame;
    logic               line_q;
    logic               bit_ok;

    always_ff @(posedge clk or posedge reset)
    begin
        if (reset)
        begin
            exp_data <= '0;
            idx      <= '0;
            phase    <= '0;
            armed    <= 1'b0;
            in_frame <= 1'b0;
            line_q   <= 1'b1;
        end
        else
        begin
            line_q <= serial_out;
            if (tx_req.start)
            begin
                exp_data <= tx_req.data;
                armed    <= 1'b1;
            end
            if (armed && !in_frame && line_q && !serial_out)
            begin
                in_frame <= 1'b1;  // edge seen one cycle after the line fell
                phase    <= 4'd2;
                idx      <= '0;
            end
            else if (in_frame)
            begin
                phase <= phase + 4'd1;
                if (phase == 4'd15)
                begin
                    idx <= idx + 4'd1;
                end
                if (phase == 4'd8 && idx == 4'd10)
                begin
                    in_frame <= 1'b0;
                    armed    <= 1'b0;
                end
            end
        end
    end

    // expected line level at the centre of bit idx
    always_comb
    begin
        case (idx)
            4'd0:    bit_ok = !serial_out;
            4'd9:    bit_ok = ^{serial_out, exp_data};  // odd count of ones
            4'd10:   bit_ok = serial_out;
            default: bit_ok = (serial_out == exp_data[3'(idx - 4'd1)]);
        endcase
    end

    reset_values: assert property (@(posedge clk)
        $fell(reset) |-> serial_out && !wb_rsp.ack && status == '0)
    else
    begin
        failures = failures + 1;
        $error("outputs not at reset values after reset");
    end

    ack_one_cycle: assert property (@(posedge clk) disable iff (reset)
        wb_rsp.ack |=> !wb_rsp.ack)
    else
    begin
        failures = failures + 1;
        $error("ack held for more than one cycle");
    end

    read_latency: assert property (@(posedge clk) disable iff (reset)
        (wb_req.cyc && $rose(wb_req.stb) && !wb_req.we) |=> wb_rsp.ack)
    else
    begin
        failures = failures + 1;
        $error("read not acknowledged in the next cycle");
    end

    write_held: assert property (@(posedge clk) disable iff (reset)
        (wb_req.cyc && wb_req.stb && wb_req.we && wb_req.adr == uart_pkg::addr_data
            && tx_busy) |=> !wb_rsp.ack)
    else
    begin
        failures = failures + 1;
        $error("data write acknowledged while the transmitter was busy");
    end

    start_takes_tx: assert property (@(posedge clk) disable iff (reset)
        tx_req.start |=> tx_busy)
    else
    begin
        failures = failures + 1;
        $error("transmitter not busy in the cycle after start");
    end

    frame_format: assert property (@(posedge clk) disable iff (reset)
        (in_frame && phase == 4'd8) |-> bit_ok)
    else
    begin
        failures = failures + 1;
        $error("wrong serial bit %0d at its centre", idx);
    end

endmodule

bind uart_link_top uart_link_checker u_checker (
    .clk        (clk),
    .reset      (reset),
    .wb_req     (wb_req),
    .wb_rsp     (wb_rsp),
    .serial_out (serial_out),
    .tx_busy    (tx_busy),
    .tx_req     (tx_req),
    .status     (u_ctrl.status)
);

`default_nettype wire
